// ==== logic/mapper_pkg.sv ====
//**********************************************************************
// Memory mapper shared definitions
//**********************************************************************
`default_nettype none

package mapper_pkg;

    // bank geometry
    localparam int num_windows = 8;
    localparam int num_regs    = 32;

    // register map
    // byte 3 goes out to the sound CPU
    localparam int mailbox_reg  = 3;
    // window i: size at 16+2i, base at 17+2i
    localparam int win_base_reg = 16;

    // low two bits of a size register
    typedef enum logic [1:0] {
        size_64k  = 2'd0,
        size_128k = 2'd1,
        size_512k = 2'd2,
        size_2m   = 2'd3
    } win_size_t;

    // one window, 10 bits
    typedef struct packed {
        win_size_t  size;
        logic [7:0] base;
    } win_entry_t;

    // all windows, 80 bits, entry 0 in the low bits
    typedef win_entry_t [num_windows-1:0] win_cfg_t;

    // 68000 bus takeover for MCU DMA
    typedef enum logic [1:0] {
        gs_idle     = 2'd0,
        gs_request  = 2'd1,
        gs_wait_bus = 2'd2,
        gs_own      = 2'd3
    } grant_state_t;

endpackage

`default_nettype wire

// ==== logic/region_decoder.sv ====
//**********************************************************************
// Address window decoder
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module region_decoder (
    input  wire [23:1]              addr,
    input  wire mapper_pkg::win_cfg_t win_cfg,
    output logic [7:0]              active,
    output logic                    reg_hit
);

    // raw per-window match, before priority
    logic [7:0] match;

    always_comb begin
        match = '0;
        for (int i = 0; i < mapper_pkg::num_windows; i++) begin
            // larger windows compare fewer upper bits
            case (win_cfg[i].size)
                mapper_pkg::size_64k:
                    match[i] = addr[23:16] == win_cfg[i].base;
                mapper_pkg::size_128k:
                    match[i] = addr[23:17] == win_cfg[i].base[7:1];
                mapper_pkg::size_512k:
                    match[i] = addr[23:19] == win_cfg[i].base[7:3];
                mapper_pkg::size_2m:
                    match[i] = addr[23:21] == win_cfg[i].base[7:5];
                default:
                    match[i] = 1'b0;
            endcase
        end
    end

    // keep the lowest set bit only
    // lower window numbers win on overlap
    assign active = match & (~match + 8'd1);

    // nothing matched, address falls in mapper register space
    assign reg_hit = ~|active;

endmodule

`default_nettype wire

// ==== logic/mapper_regs.sv ====
//**********************************************************************
// Mapper register bank
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module mapper_regs (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       reg_hit,
    input  wire  [4:0]                addr_lo,
    input  wire  [7:0]                cpu_data,
    input  wire                       cpu_wr_n,
    input  wire  [4:0]                mcu_addr,
    input  wire  [7:0]                mcu_data,
    input  wire                       mcu_wr,
    output mapper_pkg::win_cfg_t      win_cfg,
    output logic [7:0]                mcu_din,
    output logic                      mbox_load,
    output logic [7:0]                mbox_data
);

    logic [7:0] regs [mapper_pkg::num_regs];

    // arbiter, CPU owns the bank only when no window is hit
    logic       wr_en;
    logic [4:0] wr_addr;
    logic [7:0] wr_data;

    assign wr_en   = reg_hit ? ~cpu_wr_n : mcu_wr;
    assign wr_addr = reg_hit ? addr_lo   : mcu_addr;
    assign wr_data = reg_hit ? cpu_data  : mcu_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < mapper_pkg::num_regs; i++) begin
                regs[i] <= 8'd0;
            end
            mbox_load <= 1'b0;
        end else begin
            if (wr_en) begin
                regs[wr_addr] <= wr_data;
            end
            // strobe lines up with the new mailbox byte
            mbox_load <= wr_en && (wr_addr == 5'(mapper_pkg::mailbox_reg));
        end
    end

    assign mbox_data = regs[mapper_pkg::mailbox_reg];

    // MCU may read any register, no arbitration on reads
    assign mcu_din = regs[mcu_addr];

    // pack size/base pairs for the decoder
    always_comb begin
        for (int i = 0; i < mapper_pkg::num_windows; i++) begin
            win_cfg[i].size = mapper_pkg::win_size_t'(regs[mapper_pkg::win_base_reg + 2*i][1:0]);
            win_cfg[i].base = regs[mapper_pkg::win_base_reg + 2*i + 1];
        end
    end

    // a load strobe hands over the byte that the accepted write just stored
    assert property (@(posedge clk) disable iff (rst)
        mbox_load |-> $past(wr_en) && mbox_data == $past(wr_data))
    else $error("mapper_regs: mbox_load without a matching mailbox write");

endmodule

`default_nettype wire

// ==== logic/sound_mailbox.sv ====
//**********************************************************************
// Sound CPU mailbox
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module sound_mailbox (
    input  wire        clk,
    input  wire        rst,
    input  wire        mbox_load,
    input  wire  [7:0] mbox_data,
    input  wire        snd_rd,
    output logic [7:0] snd_dout,
    output logic       snd_full
);

    // single credit, held by the writer while the buffer is empty
    logic credit;

    assign credit = ~snd_full;

    // load takes the credit, sound read gives it back
    // load wins when both land together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_full <= 1'b0;
        end else if (mbox_load) begin
            snd_full <= 1'b1;
        end else if (snd_rd) begin
            snd_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mbox_load) begin
            snd_dout <= mbox_data;
        end
    end

    // advisory only, the chip overwrites an unread byte
    assert property (@(posedge clk) disable iff (rst) mbox_load |-> credit)
    else $warning("sound_mailbox: load without credit, unread byte lost");

endmodule

`default_nettype wire

// ==== logic/vblank_irq.sv ====
//**********************************************************************
// VBLANK interrupt
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module vblank_irq (
    input  wire       clk,
    input  wire       rst,
    input  wire       vint,
    input  wire [2:0] cpu_fc,
    input  wire       cpu_as_n,
    output logic      irq_n
);

    logic last_vint;
    logic vint_rise;
    logic int_ack;

    // edge detect on vblank
    assign vint_rise = vint & ~last_vint;

    // 68000 int ack cycle: FC all ones with AS asserted
    assign int_ack = (cpu_fc == 3'd7) & ~cpu_as_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_vint <= 1'b0;
            irq_n     <= 1'b1;
        end else begin
            last_vint <= vint;
            // ack has priority over a new edge
            if (int_ack) begin
                irq_n <= 1'b1;
            end else if (vint_rise) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/bus_grant.sv ====
//**********************************************************************
// 68000 bus grant sequencer
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module bus_grant (
    input  wire  clk,
    input  wire  rst,
    input  wire  cpu_cen,
    input  wire  dma_req,
    input  wire  cpu_bg_n,
    input  wire  cpu_as_n,
    input  wire  cpu_dtack_n,
    output logic cpu_br_n,
    output logic cpu_bgack_n,
    output logic dma_grant
);

    mapper_pkg::grant_state_t state;
    mapper_pkg::grant_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            mapper_pkg::gs_idle:
                if (dma_req) next_state = mapper_pkg::gs_request;
            mapper_pkg::gs_request:
                // wait for the CPU to grant
                if (!dma_req) next_state = mapper_pkg::gs_idle;
                else if (!cpu_bg_n) next_state = mapper_pkg::gs_wait_bus;
            mapper_pkg::gs_wait_bus:
                // current bus cycle must finish first
                if (!dma_req) next_state = mapper_pkg::gs_idle;
                else if (cpu_as_n && cpu_dtack_n) next_state = mapper_pkg::gs_own;
            mapper_pkg::gs_own:
                if (!dma_req) next_state = mapper_pkg::gs_idle;
            default:
                next_state = mapper_pkg::gs_idle;
        endcase
    end

    // outputs registered from the next state so they move with it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= mapper_pkg::gs_idle;
            cpu_br_n    <= 1'b1;
            cpu_bgack_n <= 1'b1;
            dma_grant   <= 1'b0;
        end else if (cpu_cen) begin
            state       <= next_state;
            cpu_br_n    <= !(next_state == mapper_pkg::gs_request ||
                             next_state == mapper_pkg::gs_wait_bus);
            cpu_bgack_n <= next_state != mapper_pkg::gs_own;
            dma_grant   <= next_state == mapper_pkg::gs_own;
        end
    end

    // BGACK taken only while BR is out and the last CPU bus cycle has ended
    assert property (@(posedge clk) disable iff (rst)
        $fell(cpu_bgack_n) |-> $past(!cpu_br_n && cpu_as_n && cpu_dtack_n))
    else $error("bus_grant: bgack taken before the bus was free, state %s", state.name());

endmodule

`default_nettype wire

// ==== logic/mapper_top.sv ====
//**********************************************************************
// Memory mapper top level
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module mapper_top (
    input  wire         clk,
    input  wire         rst,
    input  wire         cpu_cen,
    input  wire         vint,
    // 68000 side
    input  wire  [23:1] addr,
    input  wire  [15:0] cpu_dout,
    input  wire         cpu_wr_n,
    input  wire  [2:0]  cpu_fc,
    input  wire         cpu_as_n,
    input  wire         cpu_dtack_n,
    input  wire         cpu_bg_n,
    output wire  [7:0]  active,
    output wire         cpu_br_n,
    output wire         cpu_bgack_n,
    output wire         irq_n,
    // protection MCU
    input  wire  [15:0] mcu_addr,
    input  wire  [7:0]  mcu_dout,
    input  wire         mcu_wr,
    input  wire         dma_req,
    output wire  [7:0]  mcu_din,
    output wire         dma_grant,
    // sound CPU
    input  wire         snd_rd,
    output wire  [7:0]  snd_dout,
    output wire         snd_full
);

    wire mapper_pkg::win_cfg_t win_cfg;
    wire                       reg_hit;
    wire                       mbox_load;
    wire [7:0]                 mbox_data;

    region_decoder u_decoder (
        .addr    (addr),
        .win_cfg (win_cfg),
        .active  (active),
        .reg_hit (reg_hit)
    );

    // register bank sees only the low byte lane and 32 addresses
    mapper_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_hit   (reg_hit),
        .addr_lo   (addr[5:1]),
        .cpu_data  (cpu_dout[7:0]),
        .cpu_wr_n  (cpu_wr_n),
        .mcu_addr  (mcu_addr[4:0]),
        .mcu_data  (mcu_dout),
        .mcu_wr    (mcu_wr),
        .win_cfg   (win_cfg),
        .mcu_din   (mcu_din),
        .mbox_load (mbox_load),
        .mbox_data (mbox_data)
    );

    sound_mailbox u_mailbox (
        .clk       (clk),
        .rst       (rst),
        .mbox_load (mbox_load),
        .mbox_data (mbox_data),
        .snd_rd    (snd_rd),
        .snd_dout  (snd_dout),
        .snd_full  (snd_full)
    );

    vblank_irq u_irq (
        .clk      (clk),
        .rst      (rst),
        .vint     (vint),
        .cpu_fc   (cpu_fc),
        .cpu_as_n (cpu_as_n),
        .irq_n    (irq_n)
    );

    bus_grant u_grant (
        .clk         (clk),
        .rst         (rst),
        .cpu_cen     (cpu_cen),
        .dma_req     (dma_req),
        .cpu_bg_n    (cpu_bg_n),
        .cpu_as_n    (cpu_as_n),
        .cpu_dtack_n (cpu_dtack_n),
        .cpu_br_n    (cpu_br_n),
        .cpu_bgack_n (cpu_bgack_n),
        .dma_grant   (dma_grant)
    );

endmodule

`default_nettype wire

// ==== tb/mapper_tb.sv ====
//**********************************************************************
// Memory mapper testbench
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module mapper_tb;

    // DUT inputs
    logic        clk, rst, cpu_cen, vint;
    logic [23:1] addr;
    logic [15:0] cpu_dout, mcu_addr;
    logic        cpu_wr_n, cpu_as_n, cpu_dtack_n, cpu_bg_n;
    logic [2:0]  cpu_fc;
    logic [7:0]  mcu_dout;
    logic        mcu_wr, dma_req, snd_rd;

    // DUT outputs
    wire  [7:0]  active, mcu_din, snd_dout;
    wire         cpu_br_n, cpu_bgack_n, irq_n, dma_grant, snd_full;

    // model copy of the register bank
    logic [7:0]  model_regs [mapper_pkg::num_regs];
    int          seed = 95;
    logic [7:0]  mbox_val;

    mapper_top dut (
        .clk         (clk),
        .rst         (rst),
        .cpu_cen     (cpu_cen),
        .vint        (vint),
        .addr        (addr),
        .cpu_dout    (cpu_dout),
        .cpu_wr_n    (cpu_wr_n),
        .cpu_fc      (cpu_fc),
        .cpu_as_n    (cpu_as_n),
        .cpu_dtack_n (cpu_dtack_n),
        .cpu_bg_n    (cpu_bg_n),
        .active      (active),
        .cpu_br_n    (cpu_br_n),
        .cpu_bgack_n (cpu_bgack_n),
        .irq_n       (irq_n),
        .mcu_addr    (mcu_addr),
        .mcu_dout    (mcu_dout),
        .mcu_wr      (mcu_wr),
        .dma_req     (dma_req),
        .mcu_din     (mcu_din),
        .dma_grant   (dma_grant),
        .snd_rd      (snd_rd),
        .snd_dout    (snd_dout),
        .snd_full    (snd_full)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_active(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    // expected one-hot select from the model registers
    function automatic logic [7:0] ref_decode(input logic [23:1] a);
        logic [7:0] base;
        int         shift;
        ref_decode = 8'h00;
        // walk downward so the lowest matching window is left
        for (int w = mapper_pkg::num_windows - 1; w >= 0; w--) begin
            base = model_regs[mapper_pkg::win_base_reg + 2*w + 1];
            case (mapper_pkg::win_size_t'(model_regs[mapper_pkg::win_base_reg + 2*w][1:0]))
                mapper_pkg::size_64k:  shift = 0;
                mapper_pkg::size_128k: shift = 1;
                mapper_pkg::size_512k: shift = 3;
                default:               shift = 5;
            endcase
            if ((a[23:16] >> shift) == (base >> shift)) begin
                ref_decode = 8'h01 << w;
            end
        end
    endfunction

    // upper byte picks the window, bits 5:1 pick the register
    function automatic logic [23:1] make_addr(input logic [7:0] hi, input logic [4:0] idx);
        logic [9:0] mid;
        mid = $random(seed);
        make_addr = {hi, mid, idx};
    endfunction

    // one cycle with both peers optionally writing
    task automatic bus_cycle(input logic [7:0] hi, input logic cpu_we, input logic [4:0] cpu_idx,
                             input logic [7:0] cpu_val, input logic mcu_we,
                             input logic [4:0] mcu_idx, input logic [7:0] mcu_val);
        logic [23:1] a;
        logic        in_window;
        a = make_addr(hi, cpu_idx);
        in_window = ref_decode(a) != 8'h00;
        @(negedge clk);
        addr     = a;
        cpu_dout = {8'($random(seed)), cpu_val};
        cpu_wr_n = ~cpu_we;
        mcu_addr = $random(seed);
        mcu_addr[4:0] = mcu_idx;
        mcu_dout = mcu_val;
        mcu_wr   = mcu_we;
        // model follows the bank edge, after the decode check of this cycle
        #10;
        if (!in_window && cpu_we) model_regs[cpu_idx] = cpu_val;
        if (in_window && mcu_we) model_regs[mcu_idx] = mcu_val;
        @(negedge clk);
        cpu_wr_n = 1'b1;
        mcu_wr   = 1'b0;
    endtask

    // both peers write the same byte, whichever owns the bank lands it
    task automatic program_reg(input logic [4:0] idx, input logic [7:0] val);
        bus_cycle($random(seed), 1'b1, idx, val, 1'b1, idx, val);
    endtask

    task automatic readback_all();
        for (int r = 0; r < mapper_pkg::num_regs; r++) begin
            @(negedge clk);
            mcu_addr = $random(seed);
            mcu_addr[4:0] = 5'(r);
            #10;
            check_byte($sformatf("readback reg %0d", r), model_regs[r], mcu_din);
        end
    endtask

    // 0 snd_full, 1 irq_n, 2 cpu_br_n, 3 dma_grant
    function automatic logic watched(input int sel);
        case (sel)
            0:       watched = snd_full;
            1:       watched = irq_n;
            2:       watched = cpu_br_n;
            default: watched = dma_grant;
        endcase
    endfunction

    task automatic wait_level(input string what, input int sel, input logic level,
                              input logic random_cen);
        int                       n;
        mapper_pkg::grant_state_t gs;
        n = 0;
        while (watched(sel) !== level) begin
            @(negedge clk);
            // stalled clock enables stretch the grant latency
            if (random_cen) cpu_cen = $random(seed);
            n++;
            if (n > 40) begin
                gs = dut.u_grant.state;
                $display("timeout waiting for %s, grant FSM in %s", what, gs.name());
                stop_on_error();
            end
        end
        cpu_cen = 1'b1;
    endtask

    // decode compare, every cycle against the model
    always @(negedge clk) begin
        #5;
        if (!rst) check_active("decode", ref_decode(addr), active);
    end

    initial begin
        #1000000;
        $display("watchdog expired before the tests finished");
        stop_on_error();
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cpu_cen     = 1'b1;
        vint        = 1'b0;
        addr        = '0;
        cpu_dout    = '0;
        cpu_wr_n    = 1'b1;
        cpu_fc      = 3'd0;
        cpu_as_n    = 1'b1;
        cpu_dtack_n = 1'b1;
        cpu_bg_n    = 1'b1;
        mcu_addr    = '0;
        mcu_dout    = '0;
        mcu_wr      = 1'b0;
        dma_req     = 1'b0;
        snd_rd      = 1'b0;
        for (int r = 0; r < mapper_pkg::num_regs; r++) begin
            model_regs[r] = 8'h00;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // arbitration, CPU writes windows from outside them, MCU is locked out
        for (int w = 0; w < mapper_pkg::num_windows; w++) begin
            bus_cycle(8'hf0, 1'b1, 5'(16 + 2*w), 8'h00, 1'b1, 5'(w), 8'ha5);
            bus_cycle(8'hf0, 1'b1, 5'(17 + 2*w), 8'(8'h20 + w), 1'b1, 5'(w), 8'h5a);
        end
        readback_all();
        // inside a window the MCU owns the bank and the CPU is dropped
        for (int r = 0; r < 16; r++) begin
            bus_cycle(8'(8'h20 + r % 8), 1'b1, 5'(16 + r), 8'hff, 1'b1, 5'(r), $random(seed));
        end
        repeat (40) begin
            bus_cycle($random(seed), $random(seed), $random(seed), $random(seed),
                      $random(seed), $random(seed), $random(seed));
        end
        readback_all();

        // decode with random window layouts, overlaps included
        repeat (12) begin
            for (int r = 16; r < 32; r++) begin
                program_reg(5'(r), $random(seed));
            end
            // one probe at each window base, then random probes
            for (int w = 0; w < mapper_pkg::num_windows; w++) begin
                @(negedge clk);
                addr = make_addr(model_regs[17 + 2*w], $random(seed));
            end
            repeat (16) begin
                @(negedge clk);
                addr = $random(seed);
            end
        end
        readback_all();

        // mailbox, start from an empty buffer
        @(negedge clk);
        snd_rd = 1'b1;
        @(negedge clk);
        snd_rd = 1'b0;
        wait_level("snd_full clear", 0, 1'b0, 1'b0);
        mbox_val = $random(seed);
        program_reg(5'(mapper_pkg::mailbox_reg), mbox_val);
        wait_level("snd_full set", 0, 1'b1, 1'b0);
        check_byte("mailbox data", mbox_val, snd_dout);
        @(negedge clk);
        snd_rd = 1'b1;
        @(negedge clk);
        snd_rd = 1'b0;
        check_bit("credit returned", 1'b0, snd_full);
        program_reg(5'(mapper_pkg::mailbox_reg), $random(seed));
        wait_level("snd_full set again", 0, 1'b1, 1'b0);
        // load strobe is live in this cycle, read lands on top of it
        mbox_val = $random(seed);
        program_reg(5'(mapper_pkg::mailbox_reg), mbox_val);
        snd_rd = 1'b1;
        @(negedge clk);
        snd_rd = 1'b0;
        check_bit("load beats read", 1'b1, snd_full);
        check_byte("mailbox overwrite", mbox_val, snd_dout);
        @(negedge clk);
        snd_rd = 1'b1;
        @(negedge clk);
        snd_rd = 1'b0;
        check_bit("mailbox drained", 1'b0, snd_full);

        // vblank interrupt
        vint = 1'b1;
        wait_level("irq_n low", 1, 1'b0, 1'b0);
        repeat (3) begin
            @(negedge clk);
            check_bit("irq held until ack", 1'b0, irq_n);
        end
        cpu_fc   = 3'd7;
        cpu_as_n = 1'b0;
        @(negedge clk);
        cpu_fc   = 3'd0;
        cpu_as_n = 1'b1;
        wait_level("irq_n release", 1, 1'b1, 1'b0);
        // vint still high, no new edge
        repeat (4) begin
            @(negedge clk);
            check_bit("no edge no irq", 1'b1, irq_n);
        end
        vint = 1'b0;
        @(negedge clk);
        // edge and ack in the same cycle, ack wins
        vint     = 1'b1;
        cpu_fc   = 3'd7;
        cpu_as_n = 1'b0;
        @(negedge clk);
        cpu_fc   = 3'd0;
        cpu_as_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("ack beats edge", 1'b1, irq_n);
        end

        // bus grant for MCU DMA
        dma_req = 1'b1;
        wait_level("cpu_br_n low", 2, 1'b0, 1'b1);
        check_bit("bgack before grant", 1'b1, cpu_bgack_n);
        check_bit("dma_grant before grant", 1'b0, dma_grant);
        cpu_bg_n = 1'b0;
        wait_level("dma_grant high", 3, 1'b1, 1'b1);
        check_bit("bgack while owned", 1'b0, cpu_bgack_n);
        check_bit("br released while owned", 1'b1, cpu_br_n);
        dma_req  = 1'b0;
        cpu_bg_n = 1'b1;
        wait_level("dma_grant low", 3, 1'b0, 1'b1);
        check_bit("bgack idle", 1'b1, cpu_bgack_n);
        check_bit("br idle", 1'b1, cpu_br_n);

        @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/mapper_pkg.sv
logic/region_decoder.sv
logic/mapper_regs.sv
logic/sound_mailbox.sv
logic/vblank_irq.sv
logic/bus_grant.sv
logic/mapper_top.sv
tb/mapper_tb.sv
